//--- sampler_pkg.sv
`default_nettype none

package sampler_pkg;

    localparam int NUM_VOICES    = 4;
    localparam int VOICE_W       = 2;               // Enough bits to name every voice
    localparam int ADDR_W        = 5;
    localparam int ROM_WORDS     = 1 << ADDR_W;     // 32 sample words
    localparam int SAMPLE_W      = 8;
    localparam int KEY_W         = 7;               // MIDI key number
    localparam int SAMPLE_PERIOD = 16;              // Clock cycles between two addresses
    localparam int PERIOD_W      = $clog2(SAMPLE_PERIOD);
    localparam int FIFO_DEPTH    = 8;

    // Last count value of a sample period
    localparam logic [PERIOD_W-1:0] PERIOD_LAST = PERIOD_W'(SAMPLE_PERIOD - 1);

    // Key per voice, element 0 belongs to voice 0
    localparam logic [NUM_VOICES-1:0][KEY_W-1:0] VOICE_KEYS = {7'd67, 7'd64, 7'd62, 7'd60};

    typedef struct packed {
        logic             trigger;             // Single-cycle note-on strobe
        logic [KEY_W-1:0] key;
    } note_t;

    typedef struct packed {
        logic               setup;             // Single-cycle setup strobe
        logic [VOICE_W-1:0] voice;
        logic [ADDR_W-1:0]  start;
        logic [ADDR_W-1:0]  stop;              // Exclusive
    } voice_cfg_t;

    typedef struct packed {
        logic [VOICE_W-1:0] voice;
        logic [ADDR_W-1:0]  addr;
    } sample_req_t;

    typedef struct packed {
        logic [VOICE_W-1:0]  voice;
        logic [ADDR_W-1:0]   addr;
        logic [SAMPLE_W-1:0] data;
    } sample_out_t;

endpackage

`default_nettype wire

//--- instrument.sv
`timescale 1ns/1ps
`default_nettype none

module instrument #(
    parameter logic [sampler_pkg::KEY_W-1:0]   MIDI_KEY = 7'd60,
    parameter logic [sampler_pkg::VOICE_W-1:0] VOICE_ID = '0
) (
    input  logic                            clk,
    input  logic                            rst,
    input  sampler_pkg::note_t              note,
    input  sampler_pkg::voice_cfg_t         cfg,
    output logic [sampler_pkg::ADDR_W-1:0]  addr,
    output logic                            addr_valid,
    input  logic                            addr_ready   // Must come at least once per period
);

    typedef enum logic [1:0] {
        ST_SETUP,
        ST_IDLE,
        ST_PLAY
    } state_t;

    state_t state;

    logic [sampler_pkg::ADDR_W-1:0]   start_hold;
    logic [sampler_pkg::ADDR_W-1:0]   stop_hold;
    logic [sampler_pkg::ADDR_W-1:0]   last_addr;
    logic [sampler_pkg::PERIOD_W-1:0] period_cnt;
    logic                             retrig_hold;  // Retrigger waiting for the boundary
    logic                             key_hit;
    logic                             cfg_hit;
    logic                             boundary;

    assign key_hit   = note.trigger && (note.key == MIDI_KEY);
    assign cfg_hit   = cfg.setup && (cfg.voice == VOICE_ID);
    assign boundary  = (period_cnt == sampler_pkg::PERIOD_LAST);
    assign last_addr = stop_hold - 1'b1;             // Stop of 0 ends on the top word

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= ST_SETUP;
            period_cnt  <= '0;
            retrig_hold <= 1'b0;
            addr_valid  <= 1'b0;
        end else begin
            if (addr_valid && addr_ready) begin
                addr_valid <= 1'b0;                  // Arbiter took the address
            end

            case (state)
                ST_SETUP: begin
                    if (cfg_hit) begin
                        start_hold <= cfg.start;
                        stop_hold  <= cfg.stop;
                        state      <= ST_IDLE;
                    end
                end

                ST_IDLE: begin
                    if (key_hit) begin
                        addr       <= start_hold;
                        addr_valid <= 1'b1;
                        period_cnt <= '0;
                        state      <= ST_PLAY;
                    end else if (cfg_hit) begin
                        start_hold <= cfg.start;     // New range for this voice only
                        stop_hold  <= cfg.stop;
                    end
                end

                ST_PLAY: begin
                    if (boundary) begin
                        period_cnt <= '0;
                        if (key_hit || retrig_hold) begin
                            addr        <= start_hold;
                            addr_valid  <= 1'b1;
                            retrig_hold <= 1'b0;
                        end else if (addr == last_addr) begin
                            state <= ST_IDLE;        // Range exhausted
                        end else begin
                            addr       <= addr + 1'b1;
                            addr_valid <= 1'b1;
                        end
                    end else begin
                        period_cnt <= period_cnt + 1'b1;
                        if (key_hit) begin
                            retrig_hold <= 1'b1;
                        end
                    end
                end

                default: state <= ST_SETUP;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- req_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module req_arbiter (
    input  logic                                                       clk,
    input  logic                                                       rst,
    input  logic [sampler_pkg::NUM_VOICES-1:0][sampler_pkg::ADDR_W-1:0] addr,
    input  logic [sampler_pkg::NUM_VOICES-1:0]                          addr_valid,
    output logic [sampler_pkg::NUM_VOICES-1:0]                          addr_ready,
    input  logic                                                       full,
    output logic                                                       push,
    output sampler_pkg::sample_req_t                                   push_data
);

    logic [sampler_pkg::VOICE_W-1:0] last_grant;   // Voice served by the last transfer
    logic [sampler_pkg::VOICE_W-1:0] cand;
    logic [sampler_pkg::VOICE_W-1:0] grant_idx;
    logic                            grant_found;

    // Search starts one past the last grant and wraps around, so the
    // last granted voice is looked at last
    always_comb begin
        grant_found = 1'b0;
        grant_idx   = last_grant;
        cand        = last_grant;
        for (int k = 1; k <= sampler_pkg::NUM_VOICES; k++) begin
            cand = last_grant + sampler_pkg::VOICE_W'(k);
            if (!grant_found && addr_valid[cand]) begin
                grant_found = 1'b1;
                grant_idx   = cand;
            end
        end
    end

    // At most one ready and never while the FIFO is full
    always_comb begin
        addr_ready = '0;
        if (grant_found && !full) begin
            addr_ready[grant_idx] = 1'b1;
        end
    end

    assign push      = grant_found && !full;             // High exactly on a transfer
    assign push_data = '{voice: grant_idx, addr: addr[grant_idx]};

    always_ff @(posedge clk) begin
        if (rst) begin
            last_grant <= sampler_pkg::VOICE_W'(sampler_pkg::NUM_VOICES - 1);
        end else if (push) begin
            last_grant <= grant_idx;
        end
    end

endmodule

`default_nettype wire

//--- sync_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module sync_fifo #(
    parameter type T     = logic [7:0],
    parameter int  DEPTH = 4                      // Power of two so the pointers wrap
) (
    input  logic clk,
    input  logic rst,
    input  logic push,
    input  T     push_data,
    output logic full,
    input  logic pop,
    output T     head,
    output logic not_empty
);

    T mem [DEPTH];

    logic [$clog2(DEPTH)-1:0] wr_ptr;
    logic [$clog2(DEPTH)-1:0] rd_ptr;
    logic [$clog2(DEPTH):0]   count;              // One bit wider to hold DEPTH
    logic                     do_push;
    logic                     do_pop;

    assign full      = (count == DEPTH);
    assign not_empty = (count != 0);
    assign head      = mem[rd_ptr];               // Show-ahead head entry

    assign do_push = push && !full;
    assign do_pop  = pop && not_empty;

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end

            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;          // Both or neither keep the level
            endcase
        end
    end

endmodule

`default_nettype wire

//--- sample_rom.sv
`timescale 1ns/1ps
`default_nettype none

module sample_rom (
    input  logic                             clk,
    input  logic [sampler_pkg::ADDR_W-1:0]   rd_addr,
    output logic [sampler_pkg::SAMPLE_W-1:0] rd_data
);

    logic [sampler_pkg::SAMPLE_W-1:0] mem [sampler_pkg::ROM_WORDS];

    // Contents come from the hex image at elaboration
    initial begin
        $readmemh("sample_data.hex", mem);
    end

    // Registered read gives the word one cycle after the address
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

`default_nettype wire

//--- voice_fetch.sv
`timescale 1ns/1ps
`default_nettype none

module voice_fetch (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             not_empty,
    input  sampler_pkg::sample_req_t         head,
    output logic                             pop,
    output logic [sampler_pkg::ADDR_W-1:0]   rd_addr,
    input  logic [sampler_pkg::SAMPLE_W-1:0] rd_data,
    output logic                             sample_valid,
    output sampler_pkg::sample_out_t         sample
);

    logic                     req_valid;          // ROM read in flight this cycle
    sampler_pkg::sample_req_t req_tag;            // Tag that matches the ROM word

    // The stage never stalls and drains one entry per cycle
    assign pop     = not_empty;
    assign rd_addr = head.addr;

    always_ff @(posedge clk) begin
        if (rst) begin
            req_valid    <= 1'b0;
            sample_valid <= 1'b0;
        end else begin
            req_valid    <= pop;
            sample_valid <= req_valid;            // Two cycles after pop
        end
    end

    // First stage holds the tag while the ROM reads
    always_ff @(posedge clk) begin
        if (pop) begin
            req_tag <= head;
        end
    end

    // Second stage joins the tag with the returning word
    always_ff @(posedge clk) begin
        if (req_valid) begin
            sample.voice <= req_tag.voice;
            sample.addr  <= req_tag.addr;
            sample.data  <= rd_data;
        end
    end

endmodule

`default_nettype wire

//--- sampler_top.sv
`timescale 1ns/1ps
`default_nettype none

module sampler_top (
    input  logic                     clk,
    input  logic                     rst,
    input  sampler_pkg::note_t       note,
    input  sampler_pkg::voice_cfg_t  cfg,
    output logic                     sample_valid,
    output sampler_pkg::sample_out_t sample
);

    logic [sampler_pkg::NUM_VOICES-1:0][sampler_pkg::ADDR_W-1:0] voice_addr;
    logic [sampler_pkg::NUM_VOICES-1:0]                          voice_valid;
    logic [sampler_pkg::NUM_VOICES-1:0]                          voice_ready;

    logic                             fifo_full;
    logic                             fifo_push;
    logic                             fifo_pop;
    logic                             fifo_not_empty;
    sampler_pkg::sample_req_t         push_data;
    sampler_pkg::sample_req_t         fifo_head;
    logic [sampler_pkg::ADDR_W-1:0]   rom_addr;
    logic [sampler_pkg::SAMPLE_W-1:0] rom_data;

    for (genvar i = 0; i < sampler_pkg::NUM_VOICES; i++) begin : g_voice
        instrument #(
            .MIDI_KEY (sampler_pkg::VOICE_KEYS[i]),
            .VOICE_ID (sampler_pkg::VOICE_W'(i))
        ) u_voice (
            .clk        (clk),
            .rst        (rst),
            .note       (note),
            .cfg        (cfg),
            .addr       (voice_addr[i]),
            .addr_valid (voice_valid[i]),
            .addr_ready (voice_ready[i])
        );
    end

    req_arbiter u_arbiter (
        .clk        (clk),
        .rst        (rst),
        .addr       (voice_addr),
        .addr_valid (voice_valid),
        .addr_ready (voice_ready),
        .full       (fifo_full),
        .push       (fifo_push),
        .push_data  (push_data)
    );

    sync_fifo #(
        .T     (sampler_pkg::sample_req_t),
        .DEPTH (sampler_pkg::FIFO_DEPTH)
    ) u_fifo (
        .clk       (clk),
        .rst       (rst),
        .push      (fifo_push),
        .push_data (push_data),
        .full      (fifo_full),
        .pop       (fifo_pop),
        .head      (fifo_head),
        .not_empty (fifo_not_empty)
    );

    voice_fetch u_fetch (
        .clk          (clk),
        .rst          (rst),
        .not_empty    (fifo_not_empty),
        .head         (fifo_head),
        .pop          (fifo_pop),
        .rd_addr      (rom_addr),
        .rd_data      (rom_data),
        .sample_valid (sample_valid),
        .sample       (sample)
    );

    sample_rom u_rom (
        .clk     (clk),
        .rd_addr (rom_addr),
        .rd_data (rom_data)
    );

endmodule

`default_nettype wire

//--- sampler_assert.sv
`timescale 1ns/1ps
`default_nettype none

module sampler_assert #(
    parameter bit FIFO_SIDE = 1'b1                   // Set for the FIFO, clear for the arbiter
) (
    input logic                               clk,
    input logic                               rst,
    input logic                               push,
    input logic                               full,
    input logic                               pop,
    input logic                               not_empty,
    input logic [sampler_pkg::NUM_VOICES-1:0] ready
);

    int unsigned fired = 0;                          // Failed assertions so far

    if (FIFO_SIDE) begin : g_fifo
        a_no_push_full: assert property (@(posedge clk) disable iff (rst) !(push && full))
            else begin
                $error("Push while the FIFO is full");
                fired++;
            end

        a_no_pop_empty: assert property (@(posedge clk) disable iff (rst) !(pop && !not_empty))
            else begin
                $error("Pop while the FIFO is empty");
                fired++;
            end
    end else begin : g_arbiter
        // The arbiter grants a single voice per cycle
        a_one_ready: assert property (@(posedge clk) disable iff (rst) $onehot0(ready))
            else begin
                $error("More than one addr_ready high");
                fired++;
            end
    end

endmodule

`default_nettype wire

//--- sampler_tb.sv
`timescale 1ns/1ps
`default_nettype none

module sampler_tb;

    localparam int SPAN_CYCLES = sampler_pkg::ROM_WORDS * sampler_pkg::SAMPLE_PERIOD + 64;
    localparam int NUM_SPANS   = 6;                 // One settle span per wait in the tests
    localparam int WATCHDOG_NS = NUM_SPANS * SPAN_CYCLES * 10 + 2000;
    localparam int LIST_MAX    = 64;

    logic                     clk;
    logic                     rst;
    sampler_pkg::note_t       note;
    sampler_pkg::voice_cfg_t  cfg;
    logic                     sample_valid;
    sampler_pkg::sample_out_t sample;

    logic [sampler_pkg::SAMPLE_W-1:0] ref_rom [sampler_pkg::ROM_WORDS];
    logic [sampler_pkg::ADDR_W-1:0]   got_addr [sampler_pkg::NUM_VOICES][LIST_MAX];
    logic [sampler_pkg::SAMPLE_W-1:0] got_data [sampler_pkg::NUM_VOICES][LIST_MAX];
    int                               got_cnt [sampler_pkg::NUM_VOICES];
    logic [sampler_pkg::ADDR_W-1:0]   exp_addr [LIST_MAX];
    int                               exp_cnt;
    logic [sampler_pkg::ADDR_W-1:0]   range_start [sampler_pkg::NUM_VOICES];
    logic [sampler_pkg::ADDR_W-1:0]   range_stop [sampler_pkg::NUM_VOICES];
    logic [31:0]                      lfsr_state;
    int                               errors;
    int                               checks;
    int                               assert_fails;

    sampler_top uut (
        .clk          (clk),
        .rst          (rst),
        .note         (note),
        .cfg          (cfg),
        .sample_valid (sample_valid),
        .sample       (sample)
    );

    bind sync_fifo sampler_assert #(.FIFO_SIDE (1'b1)) u_fifo_chk (
        .clk (clk), .rst (rst), .push (push), .full (full),
        .pop (pop), .not_empty (not_empty), .ready ('0)
    );

    bind req_arbiter sampler_assert #(.FIFO_SIDE (1'b0)) u_arb_chk (
        .clk (clk), .rst (rst), .push (push), .full (full),
        .pop (1'b0), .not_empty (1'b1), .ready (addr_ready)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Every sample lands in the list of the voice named by its tag
    always @(posedge clk) begin
        if (sample_valid) begin
            if (got_cnt[sample.voice] < LIST_MAX) begin
                got_addr[sample.voice][got_cnt[sample.voice]] = sample.addr;
                got_data[sample.voice][got_cnt[sample.voice]] = sample.data;
                got_cnt[sample.voice] = got_cnt[sample.voice] + 1;
            end else begin
                $display("Voice %0d produced more samples than the list can hold", sample.voice);
                errors++;
            end
        end
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};   // Taps 32, 22, 2, 1
    endfunction

    task automatic draw_bits(input int n, output int val);
        val = 0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            val = (val << 1) | lfsr_state[0];
        end
    endtask

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string msg);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("[FAIL] %0d ns: %s, got %0d, expected %0d", $time, msg, actual, expected);
        end
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
    endtask

    task automatic send_cfg(input int voice, input int start, input int stop);
        @(posedge clk);
        #1;
        cfg = '{setup: 1'b1, voice: sampler_pkg::VOICE_W'(voice),
                start: sampler_pkg::ADDR_W'(start), stop: sampler_pkg::ADDR_W'(stop)};
        range_start[voice] = sampler_pkg::ADDR_W'(start);
        range_stop[voice]  = sampler_pkg::ADDR_W'(stop);
        @(posedge clk);
        #1;
        cfg = '0;
    endtask

    task automatic send_note(input int key);
        @(posedge clk);
        #1;
        note = '{trigger: 1'b1, key: sampler_pkg::KEY_W'(key)};
        @(posedge clk);
        #1;
        note = '0;
    endtask

    task automatic clear_lists;
        for (int v = 0; v < sampler_pkg::NUM_VOICES; v++) begin
            got_cnt[v] = 0;
        end
    endtask

    // Appends start up to stop-1 and treats a stop equal to start as all 32 words
    task automatic add_range(input logic [sampler_pkg::ADDR_W-1:0] start,
                             input logic [sampler_pkg::ADDR_W-1:0] stop);
        logic [sampler_pkg::ADDR_W-1:0] a;
        a = start;
        do begin
            exp_addr[exp_cnt] = a;
            exp_cnt++;
            a = a + 1'b1;
        end while (a != stop);
    endtask

    task automatic check_voice(input int v);
        for (int i = 0; i < exp_cnt && i < got_cnt[v]; i++) begin
            check_value(got_addr[v][i], exp_addr[i], $sformatf("voice %0d item %0d addr", v, i));
            check_value(got_data[v][i], ref_rom[exp_addr[i]],
                        $sformatf("voice %0d item %0d data", v, i));
        end
        check_value(got_cnt[v], exp_cnt, $sformatf("voice %0d sample count", v));
    endtask

    task automatic check_all_voices;
        for (int v = 0; v < sampler_pkg::NUM_VOICES; v++) begin
            exp_cnt = 0;
            add_range(range_start[v], range_stop[v]);
            check_voice(v);
        end
    endtask

    task automatic silent_voices;
        clear_lists();
        for (int v = 0; v < sampler_pkg::NUM_VOICES; v++) begin
            send_note(sampler_pkg::VOICE_KEYS[v]);
        end
        wait_cycles(SPAN_CYCLES);
        for (int v = 0; v < sampler_pkg::NUM_VOICES; v++) begin
            check_value(got_cnt[v], 0, $sformatf("voice %0d played before setup", v));
            send_cfg(v, 2 + 7 * v, 7 + 7 * v);
        end
        send_note(61);                               // No voice owns this key
        wait_cycles(SPAN_CYCLES);
        for (int v = 0; v < sampler_pkg::NUM_VOICES; v++) begin
            check_value(got_cnt[v], 0, $sformatf("voice %0d played a foreign key", v));
        end
    endtask

    task automatic single_note;
        send_cfg(0, 4, 10);
        clear_lists();
        send_note(sampler_pkg::VOICE_KEYS[0]);
        wait_cycles(SPAN_CYCLES);
        exp_cnt = 0;
        add_range(5'd4, 5'd10);
        check_voice(0);
        for (int v = 1; v < sampler_pkg::NUM_VOICES; v++) begin
            check_value(got_cnt[v], 0, $sformatf("voice %0d played without a note", v));
        end
    endtask

    task automatic retrigger_note;
        clear_lists();
        send_note(sampler_pkg::VOICE_KEYS[1]);
        wait_cycles(38);                             // Retrigger lands mid third period
        send_note(sampler_pkg::VOICE_KEYS[1]);
        wait_cycles(SPAN_CYCLES);
        exp_cnt = 0;
        add_range(range_start[1], range_stop[1]);
        exp_cnt = 3;                                 // Three addresses went out before it
        add_range(range_start[1], range_stop[1]);
        check_voice(1);
    endtask

    task automatic setup_isolation;
        send_cfg(2, 20, 28);
        clear_lists();
        for (int v = 0; v < sampler_pkg::NUM_VOICES; v++) begin
            send_note(sampler_pkg::VOICE_KEYS[v]);
        end
        wait_cycles(SPAN_CYCLES);
        check_all_voices();
    endtask

    task automatic voice_contention;
        int start;
        int len;
        for (int v = 0; v < sampler_pkg::NUM_VOICES; v++) begin
            draw_bits(4, start);
            draw_bits(4, len);
            send_cfg(v, start, start + len + 1);
        end
        clear_lists();
        // Notes a period apart line up the period boundaries of all voices
        for (int v = 0; v < sampler_pkg::NUM_VOICES; v++) begin
            send_note(sampler_pkg::VOICE_KEYS[v]);
            if (v < sampler_pkg::NUM_VOICES - 1) begin
                wait_cycles(sampler_pkg::SAMPLE_PERIOD - 2);
            end
        end
        wait_cycles(SPAN_CYCLES);
        check_all_voices();
    endtask

    initial begin
        errors     = 0;
        checks     = 0;
        lfsr_state = 32'h8386;
        rst        = 1'b1;
        note       = '0;
        cfg        = '0;
        clear_lists();
        $readmemh("sample_data.hex", ref_rom);
        wait_cycles(8);
        #1;
        rst = 1'b0;
        silent_voices();
        single_note();
        retrigger_note();
        setup_isolation();
        voice_contention();
        assert_fails = uut.u_fifo.u_fifo_chk.fired + uut.u_arbiter.u_arb_chk.fired;
        errors = errors + assert_fails;
        $display("Checks: %0d, errors: %0d, of them assertion failures: %0d",
                 checks, errors, assert_fails);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
        $display("Verification failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- sample_data.hex
// One 8-bit sample word per line, address 0 first
5A
7F
A4
C9
EE
13
38
5D
82
A7
CC
F1
16
3B
60
85
AA
CF
F4
19
3E
63
88
AD
D2
F7
1C
41
66
8B
B0
D5

//--- all.f
sampler_pkg.sv
instrument.sv
req_arbiter.sv
sync_fifo.sv
sample_rom.sv
voice_fetch.sv
sampler_top.sv
sampler_assert.sv
sampler_tb.sv

//--- Bender.yml
package:
  name: sampler

sources:
  - sampler_pkg.sv
  - instrument.sv
  - req_arbiter.sv
  - sync_fifo.sv
  - sample_rom.sv
  - voice_fetch.sv
  - sampler_top.sv
  - target: simulation
    files:
      - sampler_assert.sv
      - sampler_tb.sv
